// File: all.f
+incdir+include
hdl/aes_pkg.sv
hdl/aes_dec_regs.sv
hdl/aes_key_expand.sv
hdl/aes_dec_core.sv
hdl/aes_dec_top.sv
bench/aes_dec_tb.sv

// File: bench/aes_dec_tb.sv
`timescale 1ns/1ps
`include "aes_cfg.svh"

module aes_dec_tb import aes_pkg::*; ();

    localparam int NUM_KEYS    = 50;
    localparam int CTS_PER_KEY = 3;
    // reset, known vector, random keys, zero reads and idle checks
    localparam int NUM_OPS = 1 + 14 + NUM_KEYS * (5 + CTS_PER_KEY * 9) + 12 + 16;
    localparam int TIMEOUT = 20 * NUM_OPS + 200;

    logic      clk;
    logic      rst_n;
    avs_req_t  avs;
    aes_word_t avs_readdata;
    logic      avs_waitrequest;
    int        cycles;
    int        seed;

    // byte n of a block is row n mod 4, column n div 4
    aes_byte_t key_b [16];
    aes_byte_t ct_b  [16];
    aes_byte_t pt_b  [16];
    aes_byte_t ek    [176];

    aes_dec_top i_aes_dec_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .avs_i             (avs),
        .avs_readdata_o    (avs_readdata),
        .avs_waitrequest_o (avs_waitrequest)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Verification failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic check_word(input string name, input aes_word_t got, input aes_word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    function automatic aes_byte_t gmul(aes_byte_t a, aes_byte_t b);
        aes_byte_t p;
        aes_byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ x;
            end
            x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
        end
        return p;
    endfunction

    function automatic aes_word_t word_of(aes_byte_t b0, aes_byte_t b1, aes_byte_t b2,
                                          aes_byte_t b3);
        return {b3, b2, b1, b0};
    endfunction

    // flat schedule, round key r is ek[16r +: 16]
    task automatic model_expand();
        aes_byte_t t [4];
        aes_byte_t tmp;
        aes_byte_t rc;
        rc = 8'h01;
        for (int n = 0; n < 16; n++) begin
            ek[n] = key_b[n];
        end
        for (int i = 4; i < 44; i++) begin
            for (int j = 0; j < 4; j++) begin
                t[j] = ek[4 * (i - 1) + j];
            end
            if (i % 4 == 0) begin
                tmp  = t[0];
                t[0] = sbox(t[1]) ^ rc;
                t[1] = sbox(t[2]);
                t[2] = sbox(t[3]);
                t[3] = sbox(tmp);
                rc   = gmul(rc, 8'h02);
            end
            for (int j = 0; j < 4; j++) begin
                ek[4 * i + j] = ek[4 * (i - 4) + j] ^ t[j];
            end
        end
    endtask

    task automatic model_decrypt();
        aes_byte_t s [16];
        aes_byte_t u [16];
        aes_byte_t a [4];
        for (int n = 0; n < 16; n++) begin
            s[n] = ct_b[n] ^ ek[160 + n];
        end
        for (int round = 9; round >= 0; round--) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    u[r + 4 * c] = inv_sbox(s[r + 4 * ((c + 4 - r) % 4)]);
                end
            end
            for (int n = 0; n < 16; n++) begin
                s[n] = u[n] ^ ek[16 * round + n];
            end
            if (round > 0) begin
                for (int c = 0; c < 4; c++) begin
                    for (int r = 0; r < 4; r++) begin
                        a[r] = s[4 * c + r];
                    end
                    for (int r = 0; r < 4; r++) begin
                        s[4 * c + r] = gmul(a[r], 8'h0e) ^ gmul(a[(r + 1) % 4], 8'h0b) ^
                                       gmul(a[(r + 2) % 4], 8'h0d) ^ gmul(a[(r + 3) % 4], 8'h09);
                    end
                end
            end
        end
        for (int n = 0; n < 16; n++) begin
            pt_b[n] = s[n];
        end
    endtask

    // request held until waitrequest drops, accepted on the following edge
    task automatic avs_write(input int addr, input aes_word_t data);
        @(negedge clk);
        avs.write     = 1'b1;
        avs.address   = addr[`AES_ADDR_W-1:0];
        avs.writedata = data;
        while (avs_waitrequest) begin
            @(negedge clk);
        end
        @(negedge clk);
        avs.write = 1'b0;
    endtask

    task automatic avs_read(input int addr, output aes_word_t data);
        @(negedge clk);
        avs.read    = 1'b1;
        avs.address = addr[`AES_ADDR_W-1:0];
        while (avs_waitrequest) begin
            @(negedge clk);
        end
        @(negedge clk);
        data     = avs_readdata;
        avs.read = 1'b0;
    endtask

    // command write, then waitrequest must stay high for exactly busy_cycles
    task automatic run_cmd(input reg_addr_e cmd, input int busy_cycles);
        avs_write(cmd, '0);
        repeat (busy_cycles) begin
            check_flag("avs_waitrequest_o", avs_waitrequest, 1'b1);
            @(negedge clk);
        end
        check_flag("avs_waitrequest_o", avs_waitrequest, 1'b0);
    endtask

    task automatic write_key();
        for (int k = 0; k < 4; k++) begin
            avs_write(KEY0 + k, word_of(key_b[k], key_b[k + 4], key_b[k + 8], key_b[k + 12]));
        end
    endtask

    task automatic write_ct();
        for (int k = 0; k < 4; k++) begin
            avs_write(CT0 + k, word_of(ct_b[k], ct_b[k + 4], ct_b[k + 8], ct_b[k + 12]));
        end
    endtask

    task automatic read_plaintext();
        aes_word_t got;
        for (int k = 0; k < 4; k++) begin
            avs_read(k, got);
            check_word($sformatf("avs_readdata_o at address %0d", k), got,
                       word_of(pt_b[k], pt_b[k + 4], pt_b[k + 8], pt_b[k + 12]));
        end
    endtask

    initial begin
        aes_word_t                got;
        logic [127:0]             ct_vec;
        seed   = $urandom(27);
        clk    = 1'b0;
        rst_n  = 1'b0;
        avs    = '0;
        cycles = 0;

        repeat (4) begin
            @(negedge clk);
            check_flag("avs_waitrequest_o", avs_waitrequest, 1'b1);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("avs_waitrequest_o", avs_waitrequest, 1'b0);

        // FIPS-197 appendix C.1 vector
        ct_vec = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        for (int n = 0; n < 16; n++) begin
            key_b[n] = aes_byte_t'(n);
            ct_b[n]  = ct_vec[127 - 8 * n -: 8];
            pt_b[n]  = aes_byte_t'(n * 8'h11);
        end
        write_key();
        run_cmd(CMD_EXPAND, `AES_NUM_ROUNDS);
        write_ct();
        run_cmd(CMD_DECRYPT, `AES_NUM_ROUNDS + 1);
        read_plaintext();

        // one expansion serves several blocks
        for (int i = 0; i < NUM_KEYS; i++) begin
            for (int n = 0; n < 16; n++) begin
                key_b[n] = aes_byte_t'($urandom());
            end
            model_expand();
            write_key();
            run_cmd(CMD_EXPAND, `AES_NUM_ROUNDS);
            for (int j = 0; j < CTS_PER_KEY; j++) begin
                for (int n = 0; n < 16; n++) begin
                    ct_b[n] = aes_byte_t'($urandom());
                end
                model_decrypt();
                write_ct();
                run_cmd(CMD_DECRYPT, `AES_NUM_ROUNDS + 1);
                read_plaintext();
            end
        end

        for (int a = 4; a < 16; a++) begin
            avs_read(a, got);
            check_word($sformatf("avs_readdata_o at address %0d", a), got, '0);
        end

        // no read strobe, every address including the plaintext words
        for (int a = 0; a < 16; a++) begin
            @(negedge clk);
            avs.address = a[`AES_ADDR_W-1:0];
            @(negedge clk);
            check_word("avs_readdata_o with read low", avs_readdata, '0);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: hdl/aes_dec_top.sv
`timescale 1ns/1ps

module aes_dec_top import aes_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  avs_req_t  avs_i,
    output aes_word_t avs_readdata_o,
    output logic      avs_waitrequest_o
);

    logic       expand_start;
    logic       expand_busy;
    logic       decrypt_start;
    logic       decrypt_busy;
    aes_block_t cipher_key;
    aes_block_t ciphertext;
    aes_block_t plaintext;
    logic       plaintext_valid;
    rk_idx_t    rk_idx;
    aes_block_t round_key;

    aes_dec_regs i_aes_dec_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .avs_i             (avs_i),
        .expand_busy_i     (expand_busy),
        .decrypt_busy_i    (decrypt_busy),
        .plaintext_i       (plaintext),
        .plaintext_valid_i (plaintext_valid),
        .avs_readdata_o    (avs_readdata_o),
        .avs_waitrequest_o (avs_waitrequest_o),
        .expand_start_o    (expand_start),
        .decrypt_start_o   (decrypt_start),
        .cipher_key_o      (cipher_key),
        .ciphertext_o      (ciphertext)
    );

    aes_key_expand i_aes_key_expand (
        .clk            (clk),
        .rst_n          (rst_n),
        .expand_start_i (expand_start),
        .cipher_key_i   (cipher_key),
        .rk_idx_i       (rk_idx),
        .expand_busy_o  (expand_busy),
        .round_key_o    (round_key)
    );

    aes_dec_core i_aes_dec_core (
        .clk               (clk),
        .rst_n             (rst_n),
        .decrypt_start_i   (decrypt_start),
        .ciphertext_i      (ciphertext),
        .round_key_i       (round_key),
        .decrypt_busy_o    (decrypt_busy),
        .rk_idx_o          (rk_idx),
        .plaintext_o       (plaintext),
        .plaintext_valid_o (plaintext_valid)
    );

endmodule

// File: hdl/aes_dec_core.sv
`timescale 1ns/1ps
`include "aes_cfg.svh"

module aes_dec_core import aes_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       decrypt_start_i,
    input  aes_block_t ciphertext_i,
    input  aes_block_t round_key_i,
    output logic       decrypt_busy_o,
    output rk_idx_t    rk_idx_o,
    output aes_block_t plaintext_o,
    output logic       plaintext_valid_o
);

    core_state_e state_q;
    rk_idx_t     cnt_q;
    aes_block_t  data_q;
    aes_block_t  ark;
    aes_block_t  imc;

    // inverse shift rows and inverse sub bytes in one pass
    function automatic aes_block_t inv_shift_sub(aes_block_t b);
        aes_block_t res;
        int         src;
        res = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                // row r was rotated left by r columns
                src = r + 4 * ((c + 4 - r) % 4);
                res = set_byte(res, r + 4 * c, inv_sbox(get_byte(b, src)));
            end
        end
        return res;
    endfunction

    function automatic aes_block_t inv_mix_columns(aes_block_t b);
        aes_byte_t  a  [4];
        aes_byte_t  x2 [4];
        aes_byte_t  x4 [4];
        aes_byte_t  x8 [4];
        aes_block_t res;
        int         n1;
        int         n2;
        int         n3;
        res = '0;
        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < 4; i++) begin
                a[i]  = get_byte(b, 4 * c + i);
                x2[i] = xtime(a[i]);
                x4[i] = xtime(x2[i]);
                x8[i] = xtime(x4[i]);
            end
            for (int r = 0; r < 4; r++) begin
                n1 = (r + 1) % 4;
                n2 = (r + 2) % 4;
                n3 = (r + 3) % 4;
                // row r is 0e*a[r] ^ 0b*a[r+1] ^ 0d*a[r+2] ^ 09*a[r+3]
                res = set_byte(res, 4 * c + r,
                    (x8[r] ^ x4[r] ^ x2[r]) ^ (x8[n1] ^ x2[n1] ^ a[n1]) ^
                    (x8[n2] ^ x4[n2] ^ a[n2]) ^ (x8[n3] ^ a[n3]));
            end
        end
        return res;
    endfunction

    assign ark = inv_shift_sub(data_q) ^ round_key_i;
    assign imc = inv_mix_columns(ark);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= CORE_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                CORE_IDLE: begin
                    if (decrypt_start_i) begin
                        state_q <= CORE_FIRST;
                        cnt_q   <= rk_idx_t'(`AES_NUM_ROUNDS);
                    end
                end
                CORE_FIRST: begin
                    state_q <= CORE_ROUND;
                    cnt_q   <= cnt_q - 1'b1;
                end
                CORE_ROUND: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == rk_idx_t'(1)) begin
                        state_q <= CORE_LAST;
                    end
                end
                CORE_LAST: begin
                    state_q <= CORE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CORE_IDLE && decrypt_start_i) begin
            data_q <= ciphertext_i;
        end else if (state_q == CORE_FIRST) begin
            data_q <= data_q ^ round_key_i;
        end else if (state_q == CORE_ROUND) begin
            data_q <= imc;
        end
    end

    assign decrypt_busy_o    = (state_q != CORE_IDLE);
    assign rk_idx_o          = cnt_q;
    // last round has no mix, result goes straight out
    assign plaintext_o       = ark;
    assign plaintext_valid_o = (state_q == CORE_LAST);

    // one FIRST, nine ROUND, then LAST
    assert property (@(posedge clk) disable iff (!rst_n)
        plaintext_valid_o |-> $past(decrypt_start_i, `AES_NUM_ROUNDS + 1));

endmodule

// File: hdl/aes_key_expand.sv
`timescale 1ns/1ps
`include "aes_cfg.svh"

module aes_key_expand import aes_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       expand_start_i,
    input  aes_block_t cipher_key_i,
    input  rk_idx_t    rk_idx_i,
    output logic       expand_busy_o,
    output aes_block_t round_key_o
);

    localparam rk_idx_t LAST_IDX = rk_idx_t'(`AES_NUM_ROUNDS);

    aes_block_t  rk_mem [0:`AES_NUM_ROUNDS];
    kexp_state_e state_q;
    rk_idx_t     idx_q;
    aes_byte_t   rcon_q;
    aes_block_t  prev_key;
    aes_word_t   rot_w;
    aes_word_t   rot_sub;
    aes_word_t   w0;
    aes_word_t   w1;
    aes_word_t   w2;
    aes_word_t   w3;

    // idx_q stays in 1..11, so the previous key is always stored
    assign prev_key = rk_mem[idx_q - 1'b1];

    // RotWord then SubWord on the last column
    assign rot_w = {prev_key[23:0], prev_key[31:24]};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rot_sub[8*i +: 8] = sbox(rot_w[8*i +: 8]);
        end
    end

    assign w0 = prev_key[127:96] ^ rot_sub ^ {rcon_q, 24'h000000};
    assign w1 = prev_key[95:64] ^ w0;
    assign w2 = prev_key[63:32] ^ w1;
    assign w3 = prev_key[31:0] ^ w2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= KEXP_IDLE;
            idx_q   <= rk_idx_t'(1);
            rcon_q  <= 8'h01;
        end else begin
            case (state_q)
                KEXP_IDLE: begin
                    if (expand_start_i) begin
                        state_q <= KEXP_RUN;
                        idx_q   <= rk_idx_t'(1);
                        rcon_q  <= 8'h01;
                    end
                end
                KEXP_RUN: begin
                    idx_q  <= idx_q + 1'b1;
                    rcon_q <= xtime(rcon_q);
                    if (idx_q == LAST_IDX) begin
                        state_q <= KEXP_IDLE;
                    end
                end
            endcase
        end
    end

    // round key 0 is the cipher key itself
    always_ff @(posedge clk) begin
        if (state_q == KEXP_IDLE && expand_start_i) begin
            rk_mem[0] <= cipher_key_i;
        end else if (state_q == KEXP_RUN) begin
            rk_mem[idx_q] <= {w0, w1, w2, w3};
        end
    end

    assign expand_busy_o = (state_q == KEXP_RUN);
    assign round_key_o   = rk_mem[rk_idx_i];

    // the core only ever asks for one of the eleven stored keys
    assert property (@(posedge clk) disable iff (!rst_n) rk_idx_i <= LAST_IDX);

endmodule

// File: hdl/aes_dec_regs.sv
`timescale 1ns/1ps

module aes_dec_regs import aes_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  avs_req_t   avs_i,
    input  logic       expand_busy_i,
    input  logic       decrypt_busy_i,
    input  aes_block_t plaintext_i,
    input  logic       plaintext_valid_i,
    output aes_word_t  avs_readdata_o,
    output logic       avs_waitrequest_o,
    output logic       expand_start_o,
    output logic       decrypt_start_o,
    output aes_block_t cipher_key_o,
    output aes_block_t ciphertext_o
);

    reg_addr_e  addr;
    logic       wr_acc;
    logic       wait_q;
    aes_block_t key_q;
    aes_block_t ct_q;
    aes_block_t result_q;

    assign addr   = reg_addr_e'(avs_i.address);
    assign wr_acc = avs_i.write && !avs_waitrequest_o;

    // command writes start the engines directly, no data stored
    assign expand_start_o  = wr_acc && (addr == CMD_EXPAND);
    assign decrypt_start_o = wr_acc && (addr == CMD_DECRYPT);

    // high through reset, and while a start is still in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_q <= 1'b1;
        end else begin
            wait_q <= expand_start_o || decrypt_start_o;
        end
    end

    assign avs_waitrequest_o = wait_q || expand_busy_i || decrypt_busy_i;

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            case (addr)
                KEY0, KEY1, KEY2, KEY3: begin
                    key_q <= put_word(key_q, avs_i.address[1:0], avs_i.writedata);
                end
                CT0, CT1, CT2, CT3: begin
                    ct_q <= put_word(ct_q, avs_i.address[1:0], avs_i.writedata);
                end
            endcase
        end
        if (plaintext_valid_i) begin
            result_q <= plaintext_i;
        end
    end

    assign cipher_key_o = key_q;
    assign ciphertext_o = ct_q;

    // the key addresses read back as plaintext
    always_comb begin
        avs_readdata_o = '0;
        if (avs_i.read) begin
            case (addr)
                KEY0, KEY1, KEY2, KEY3: begin
                    avs_readdata_o = get_word(result_q, avs_i.address[1:0]);
                end
                default: begin
                    avs_readdata_o = '0;
                end
            endcase
        end
    end

    // the two engines never run at the same time
    assert property (@(posedge clk) disable iff (!rst_n)
        !(expand_busy_i && decrypt_busy_i));

    // each engine reports busy on the cycle after its start
    assert property (@(posedge clk) disable iff (!rst_n)
        expand_start_o |=> expand_busy_i);
    assert property (@(posedge clk) disable iff (!rst_n)
        decrypt_start_o |=> decrypt_busy_i);

endmodule

// File: hdl/aes_pkg.sv
`include "aes_cfg.svh"

package aes_pkg;

    typedef logic [`AES_BYTE_W-1:0] aes_byte_t;
    typedef logic [`AES_WORD_W-1:0] aes_word_t;
    typedef logic [16*`AES_BYTE_W-1:0] aes_block_t;
    typedef logic [`AES_RK_IDX_W-1:0] rk_idx_t;

    // reads of KEY0..KEY3 return plaintext words PT0..PT3
    typedef enum logic [`AES_ADDR_W-1:0] {
        KEY0        = `AES_REG_KEY0,
        KEY1        = `AES_REG_KEY0 + 1,
        KEY2        = `AES_REG_KEY0 + 2,
        KEY3        = `AES_REG_KEY0 + 3,
        CT0         = `AES_REG_CT0,
        CT1         = `AES_REG_CT0 + 1,
        CT2         = `AES_REG_CT0 + 2,
        CT3         = `AES_REG_CT0 + 3,
        CMD_EXPAND  = `AES_REG_CMD_EXPAND,
        CMD_DECRYPT = `AES_REG_CMD_DECRYPT
    } reg_addr_e;

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_FIRST,
        CORE_ROUND,
        CORE_LAST
    } core_state_e;

    typedef enum logic {
        KEXP_IDLE,
        KEXP_RUN
    } kexp_state_e;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`AES_ADDR_W-1:0] address;
        aes_word_t              writedata;
    } avs_req_t;

    // entry 0 sits in the top byte
    localparam logic [2047:0] SBOX_TBL = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    localparam logic [2047:0] INV_SBOX_TBL = {
        128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
    };

    function automatic aes_byte_t sbox(aes_byte_t b);
        return SBOX_TBL[8*(255-b) +: 8];
    endfunction

    function automatic aes_byte_t inv_sbox(aes_byte_t b);
        return INV_SBOX_TBL[8*(255-b) +: 8];
    endfunction

    // multiply by x in GF(2^8)
    function automatic aes_byte_t xtime(aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // byte n of the block, byte 0 in the top bits
    function automatic aes_byte_t get_byte(aes_block_t b, int unsigned n);
        return b[8*(15-n) +: 8];
    endfunction

    function automatic aes_block_t set_byte(aes_block_t b, int unsigned n, aes_byte_t v);
        aes_block_t res;
        res = b;
        res[8*(15-n) +: 8] = v;
        return res;
    endfunction

    // bus word k holds bytes k, k+4, k+8, k+12 from low to high
    function automatic aes_word_t get_word(aes_block_t b, int unsigned k);
        return {get_byte(b, k + 12), get_byte(b, k + 8), get_byte(b, k + 4), get_byte(b, k)};
    endfunction

    function automatic aes_block_t put_word(aes_block_t b, int unsigned k, aes_word_t w);
        aes_block_t res;
        res = b;
        for (int i = 0; i < 4; i++) begin
            res = set_byte(res, k + 4 * i, w[8*i +: 8]);
        end
        return res;
    endfunction

endpackage

// File: include/aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// datapath widths
`define AES_BYTE_W 8
`define AES_WORD_W 32

// bus address width, 16 word locations
`define AES_ADDR_W 4

// AES-128 uses ten rounds, so eleven round keys
`define AES_NUM_ROUNDS 10
`define AES_RK_IDX_W 4

// register map, base of each group
`define AES_REG_KEY0 0
`define AES_REG_CT0 4
`define AES_REG_CMD_EXPAND 8
`define AES_REG_CMD_DECRYPT 9

`endif
